//--- filelist.f
+incdir+logic
logic/hist_pkg.sv
logic/hist_bank_ram.sv
logic/hist_builder.sv
logic/hist_readout.sv
logic/hist_top.sv
test/tb_hist_top.sv

//--- logic/hist_bank_ram.sv
`default_nettype none

module hist_bank_ram
    import hist_pkg::*;
(
    input  logic   clk,
    input  logic   combin_res,
    // builder read-modify-write port
    input  logic   upd_en,
    input  logic   upd_bank,
    input  addr_t  upd_addr,
    input  count_t upd_count_new,
    output count_t upd_count_old,
    // lazy bank clear
    input  logic   clr_en,
    input  logic   clr_bank,
    // readout port
    input  logic   rd_bank,
    input  addr_t  rd_addr,
    output count_t rd_count
);

    // one entry per pixel and bin
    localparam int DEPTH = 1 << ADDR_W;

    // count storage, two banks
    count_t cnt_mem [2][DEPTH];

    // per-bin valid flags, one vector per bank
    logic [DEPTH-1:0] vld_bits [2];

    // valid flags, bank clear and first touch
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            vld_bits[0] <= '0;
            vld_bits[1] <= '0;
        end else begin
            // whole bank invalid in one cycle
            if (clr_en) begin
                vld_bits[clr_bank] <= '0;
            end
            // first touch of a bin marks it live
            if (upd_en) begin
                vld_bits[upd_bank][upd_addr] <= 1'b1;
            end
        end
    end

    // count write, same edge as the valid bit
    always_ff @(posedge clk) begin
        if (upd_en) begin
            cnt_mem[upd_bank][upd_addr] <= upd_count_new;
        end
    end

    // builder read, stale contents of a cleared bin show as zero
    always_comb begin
        if (vld_bits[upd_bank][upd_addr]) begin
            upd_count_old = cnt_mem[upd_bank][upd_addr];
        end else begin
            upd_count_old = '0;
        end
    end

    // readout read, same masking
    always_comb begin
        if (vld_bits[rd_bank][rd_addr]) begin
            rd_count = cnt_mem[rd_bank][rd_addr];
        end else begin
            rd_count = '0;
        end
    end

    // builder must never clear the bank it is still counting into
    a_no_upd_clr_same_bank : assert property (
        @(posedge clk) disable iff (!combin_res)
        !(upd_en && clr_en && (upd_bank == clr_bank))
    ) else $error("hist_bank_ram: update and clear hit bank %0d", upd_bank);

endmodule

`default_nettype wire

//--- logic/hist_builder.sv
`default_nettype none

`include "hist_defs.svh"

module hist_builder
    import hist_pkg::*;
(
    input  logic     clk,
    input  logic     combin_res,
    // event stream
    input  logic     ev_valid,
    input  bin_idx_t ev_bin,
    output logic     ev_ready,
    // count update
    output logic     upd_en,
    output logic     upd_bank,
    output addr_t    upd_addr,
    input  count_t   upd_count_old,
    output count_t   upd_count_new,
    // bank clear
    output logic     clr_en,
    output logic     clr_bank,
    // handoff to readout
    output logic     set_done,
    output logic     done_bank,
    input  logic     rd_busy
);

    // counter widths, one extra bit keeps a count of one legal
    localparam int CODE_W = $clog2(`HIST_CODES_PER_PIXEL + 1);
    localparam int ACQ_W  = $clog2(`HIST_ACQ_NUM + 1);

    logic [CODE_W-1:0] code_cnt;
    pix_idx_t          pix_cnt;
    logic [ACQ_W-1:0]  acq_cnt;

    // bank currently being filled
    logic fill_bank;
    // set finished but readout still owns the other bank
    logic swap_pend;

    logic accept;
    logic code_last;
    logic pix_last;
    logic acq_last;
    logic last_event;
    logic swap;

    // wrap points of the three nested counters
    assign code_last = (code_cnt == CODE_W'(`HIST_CODES_PER_PIXEL - 1));
    assign pix_last  = (pix_cnt == pix_idx_t'(`HIST_PIXEL_NUM - 1));
    assign acq_last  = (acq_cnt == ACQ_W'(`HIST_ACQ_NUM - 1));

    // only stall is a pending swap
    assign ev_ready   = !swap_pend;
    assign accept     = ev_valid && ev_ready;
    assign last_event = accept && code_last && pix_last && acq_last;

    // swap as soon as the readout has let go of the old bank
    assign swap = !rd_busy && (last_event || swap_pend);

    // update port, pixel index above the tdc code
    assign upd_en   = accept;
    assign upd_bank = fill_bank;
    assign upd_addr = {pix_cnt, ev_bin};

    // saturating increment
    always_comb begin
        if (upd_count_old == '1) begin
            upd_count_new = upd_count_old;
        end else begin
            upd_count_new = upd_count_old + count_t'(1);
        end
    end

    // clear the bank about to be filled on the swap edge
    assign clr_en   = swap;
    assign clr_bank = !fill_bank;

    // code, pixel and acquisition position
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            code_cnt <= '0;
            pix_cnt  <= '0;
            acq_cnt  <= '0;
        end else if (accept) begin
            if (code_last) begin
                code_cnt <= '0;
                if (pix_last) begin
                    pix_cnt <= '0;
                    // set boundary, acquisitions restart
                    if (acq_last) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + ACQ_W'(1);
                    end
                end else begin
                    pix_cnt <= pix_cnt + pix_idx_t'(1);
                end
            end else begin
                code_cnt <= code_cnt + CODE_W'(1);
            end
        end
    end

    // bank select, stall flag and done pulse
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            fill_bank <= 1'b0;
            swap_pend <= 1'b0;
            set_done  <= 1'b0;
            done_bank <= 1'b0;
        end else begin
            set_done <= swap;
            if (swap) begin
                // hand the finished bank over
                done_bank <= fill_bank;
                fill_bank <= !fill_bank;
                swap_pend <= 1'b0;
            end else if (last_event) begin
                // readout busy, hold input until it drains
                swap_pend <= 1'b1;
            end
        end
    end

    a_done_one_cycle : assert property (
        @(posedge clk) disable iff (!combin_res)
        set_done |=> !set_done
    ) else $error("hist_builder: set_done longer than one cycle");

endmodule

`default_nettype wire

//--- logic/hist_defs.svh
`ifndef HIST_DEFS_SVH
`define HIST_DEFS_SVH

// tdc bins per histogram
`define HIST_BIN_NUM 16

// pixels in the array
`define HIST_PIXEL_NUM 4

// consecutive codes each pixel delivers per acquisition
`define HIST_CODES_PER_PIXEL 5

// acquisitions summed into one histogram set
`define HIST_ACQ_NUM 4

// bin count width, saturates at all ones
`define HIST_COUNT_W 4

// credit pool of the readout stream
`define HIST_CREDITS 4

`endif

//--- logic/hist_pkg.sv
`default_nettype none

`include "hist_defs.svh"

package hist_pkg;

    // derived index widths
    localparam int BIN_W  = $clog2(`HIST_BIN_NUM);
    localparam int PIX_W  = $clog2(`HIST_PIXEL_NUM);
    // bank address is pixel above bin
    localparam int ADDR_W = PIX_W + BIN_W;

    typedef logic [BIN_W-1:0]         bin_idx_t;
    typedef logic [PIX_W-1:0]         pix_idx_t;
    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic [`HIST_COUNT_W-1:0] count_t;

    // readout engine states
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_STREAM,
        RD_DONE
    } rd_state_t;

endpackage

`default_nettype wire

//--- logic/hist_readout.sv
`default_nettype none

`include "hist_defs.svh"

module hist_readout
    import hist_pkg::*;
(
    input  logic     clk,
    input  logic     combin_res,
    // handoff from builder
    input  logic     set_done,
    input  logic     done_bank,
    output logic     rd_busy,
    // bank read port
    output logic     rd_bank,
    output addr_t    rd_addr,
    input  count_t   rd_count,
    // sink side
    input  logic     credit_ret,
    output logic     out_valid,
    output pix_idx_t out_pixel,
    output bin_idx_t out_bin,
    output count_t   out_count,
    output logic     out_bank,
    output logic     out_last
);

    // room for the full pool value
    localparam int CRED_W = $clog2(`HIST_CREDITS + 1);

    rd_state_t         state;
    logic [CRED_W-1:0] credits;
    logic              cur_bank;
    pix_idx_t          scan_pix;
    bin_idx_t          scan_bin;

    logic send;
    logic scan_bin_last;
    logic scan_end;

    // one beat per cycle, only with a credit in hand
    assign send = (state == RD_STREAM) && (credits != '0);

    assign scan_bin_last = (scan_bin == bin_idx_t'(`HIST_BIN_NUM - 1));
    assign scan_end      = scan_bin_last && (scan_pix == pix_idx_t'(`HIST_PIXEL_NUM - 1));

    assign rd_busy = (state != RD_IDLE);
    assign rd_bank = cur_bank;
    assign rd_addr = {scan_pix, scan_bin};

    // state machine and scan position
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state    <= RD_IDLE;
            cur_bank <= 1'b0;
            scan_pix <= '0;
            scan_bin <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (set_done) begin
                        state    <= RD_STREAM;
                        cur_bank <= done_bank;
                        scan_pix <= '0;
                        scan_bin <= '0;
                    end
                end
                RD_STREAM: begin
                    // address holds while out of credits
                    if (send) begin
                        if (scan_end) begin
                            state <= RD_DONE;
                        end else if (scan_bin_last) begin
                            scan_bin <= '0;
                            scan_pix <= scan_pix + pix_idx_t'(1);
                        end else begin
                            scan_bin <= scan_bin + bin_idx_t'(1);
                        end
                    end
                end
                RD_DONE: begin
                    // last beat on the wire, bank released next cycle
                    state <= RD_IDLE;
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // credit pool, spend and return may coincide
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            credits <= CRED_W'(`HIST_CREDITS);
        end else begin
            credits <= credits + CRED_W'(credit_ret) - CRED_W'(send);
        end
    end

    // beat strobe and end marker
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= send;
            out_last  <= send && scan_end;
        end
    end

    // beat payload, captured from the combinational bank read
    always_ff @(posedge clk) begin
        if (send) begin
            out_pixel <= scan_pix;
            out_bin   <= scan_bin;
            out_count <= rd_count;
            out_bank  <= cur_bank;
        end
    end

    // sink returned more than it was given
    a_credit_bound : assert property (
        @(posedge clk) disable iff (!combin_res)
        credits <= CRED_W'(`HIST_CREDITS)
    ) else $error("hist_readout: credit count %0d above pool", credits);

    // beat on the wire is still owed back, pool cannot be full
    a_beat_has_credit : assert property (
        @(posedge clk) disable iff (!combin_res)
        out_valid |-> (credits < CRED_W'(`HIST_CREDITS))
    ) else $error("hist_readout: beat sent but credit pool full");

endmodule

`default_nettype wire

//--- logic/hist_top.sv
`default_nettype none

module hist_top
    import hist_pkg::*;
(
    input  logic     clk,
    input  logic     combin_res,
    // tdc code stream
    input  logic     ev_valid,
    input  bin_idx_t ev_bin,
    output logic     ev_ready,
    // histogram stream to the sink
    output logic     out_valid,
    output pix_idx_t out_pixel,
    output bin_idx_t out_bin,
    output count_t   out_count,
    output logic     out_bank,
    output logic     out_last,
    input  logic     credit_ret
);

    // builder to memory
    logic   upd_en;
    logic   upd_bank;
    addr_t  upd_addr;
    count_t upd_count_old;
    count_t upd_count_new;
    logic   clr_en;
    logic   clr_bank;

    // builder to readout
    logic set_done;
    logic done_bank;
    logic rd_busy;

    // readout to memory
    logic   rd_bank;
    addr_t  rd_addr;
    count_t rd_count;

    hist_builder u_builder (
        .clk           (clk),
        .combin_res    (combin_res),
        .ev_valid      (ev_valid),
        .ev_bin        (ev_bin),
        .ev_ready      (ev_ready),
        .upd_en        (upd_en),
        .upd_bank      (upd_bank),
        .upd_addr      (upd_addr),
        .upd_count_old (upd_count_old),
        .upd_count_new (upd_count_new),
        .clr_en        (clr_en),
        .clr_bank      (clr_bank),
        .set_done      (set_done),
        .done_bank     (done_bank),
        .rd_busy       (rd_busy)
    );

    hist_bank_ram u_bank_ram (
        .clk           (clk),
        .combin_res    (combin_res),
        .upd_en        (upd_en),
        .upd_bank      (upd_bank),
        .upd_addr      (upd_addr),
        .upd_count_new (upd_count_new),
        .upd_count_old (upd_count_old),
        .clr_en        (clr_en),
        .clr_bank      (clr_bank),
        .rd_bank       (rd_bank),
        .rd_addr       (rd_addr),
        .rd_count      (rd_count)
    );

    hist_readout u_readout (
        .clk        (clk),
        .combin_res (combin_res),
        .set_done   (set_done),
        .done_bank  (done_bank),
        .rd_busy    (rd_busy),
        .rd_bank    (rd_bank),
        .rd_addr    (rd_addr),
        .rd_count   (rd_count),
        .credit_ret (credit_ret),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count),
        .out_bank   (out_bank),
        .out_last   (out_last)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_hist_top -f filelist.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_hist_top > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0

//--- test/tb_hist_top.sv
`default_nettype none

`include "hist_defs.svh"

module tb_hist_top
    import hist_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BIN_NUM      = `HIST_BIN_NUM;
    localparam int PIX_NUM      = `HIST_PIXEL_NUM;
    localparam int CODES        = `HIST_CODES_PER_PIXEL;
    localparam int ACQS         = `HIST_ACQ_NUM;
    localparam int COUNT_MAX    = (1 << `HIST_COUNT_W) - 1;
    localparam int CREDITS      = `HIST_CREDITS;
    localparam int SET_EVENTS   = CODES * PIX_NUM * ACQS;
    localparam int SET_BEATS    = PIX_NUM * BIN_NUM;
    localparam int NUM_SETS     = 10;
    localparam int TOTAL_EVENTS = NUM_SETS * SET_EVENTS;
    localparam int CLK_HALF     = 2;
    // worst case cycles per event incl. readout stalls and credit gaps
    localparam int STALL_FACTOR = 32;
    localparam int WATCHDOG_NS  = TOTAL_EVENTS * STALL_FACTOR * 2 * CLK_HALF;

    logic     clk;
    logic     combin_res;
    logic     ev_valid;
    bin_idx_t ev_bin;
    logic     ev_ready;
    logic     out_valid;
    pix_idx_t out_pixel;
    bin_idx_t out_bin;
    count_t   out_count;
    logic     out_bank;
    logic     out_last;
    logic     credit_ret;

    logic [15:0] lfsr_q;

    // reference model, one count array per bank
    int model_cnt [2][SET_BEATS];
    // nonzero map of each bank at its last close
    bit stale_nz [2][SET_BEATS];
    int fill_bank_m;
    int acc_in_set;
    int acc_total;

    // expected beats of finished sets, pixel-major
    int exp_cnt_q [$];
    bit exp_lazy_q [$];

    int sets_read;
    int beat_idx;
    int outstanding;
    int gap_left;
    // sample points since the last beat of a set
    int since_last;

    // per-set stimulus mode
    bit       rep_mode [NUM_SETS];
    bin_idx_t rep_bin [NUM_SETS];

    int mism_errs;
    int other_errs;
    int beats_checked;
    int sat_seen;
    int lazy_seen;
    int stall_offers;

    hist_top dut (
        .clk        (clk),
        .combin_res (combin_res),
        .ev_valid   (ev_valid),
        .ev_bin     (ev_bin),
        .ev_ready   (ev_ready),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count),
        .out_bank   (out_bank),
        .out_last   (out_last),
        .credit_ret (credit_ret)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // 16-bit galois lfsr, taps 16,14,13,11
    function automatic logic [15:0] galois_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_q[0]);
            lfsr_q = galois_step(lfsr_q);
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input int expv, input int actv);
        mism_errs++;
        $display("MISMATCH %s expected %0d actual %0d (set %0d beat %0d)",
                 name, expv, actv, sets_read, beat_idx);
    endtask

    task automatic report_failure(input string what);
        other_errs++;
        $display("ERROR %s", what);
    endtask

    // snapshot finished bank, then swap and zero the new fill bank
    task automatic close_set();
        int a;
        for (a = 0; a < SET_BEATS; a++) begin
            exp_cnt_q.push_back(model_cnt[fill_bank_m][a]);
            // zero now though nonzero two sets ago
            exp_lazy_q.push_back((model_cnt[fill_bank_m][a] == 0) && stale_nz[fill_bank_m][a]);
            stale_nz[fill_bank_m][a] = (model_cnt[fill_bank_m][a] != 0);
        end
        fill_bank_m = 1 - fill_bank_m;
        for (a = 0; a < SET_BEATS; a++) begin
            model_cnt[fill_bank_m][a] = 0;
        end
    endtask

    // accepted event, pixel follows from position in set
    task automatic apply_event(input bin_idx_t bin);
        int pix;
        int addr;
        pix  = (acc_in_set / CODES) % PIX_NUM;
        addr = pix * BIN_NUM + int'(bin);
        if (model_cnt[fill_bank_m][addr] < COUNT_MAX) begin
            model_cnt[fill_bank_m][addr]++;
        end
        acc_in_set++;
        acc_total++;
        if (acc_in_set == SET_EVENTS) begin
            acc_in_set = 0;
            close_set();
        end
    endtask

    task automatic check_beat();
        int exp_c;
        bit lazy;
        int exp_pix;
        int exp_bin;
        beats_checked++;
        if (exp_cnt_q.size() == 0) begin
            report_failure("beat arrived while no finished set was pending in the model");
        end else begin
            exp_c   = exp_cnt_q.pop_front();
            lazy    = exp_lazy_q.pop_front();
            exp_pix = beat_idx / BIN_NUM;
            exp_bin = beat_idx % BIN_NUM;
            assert (int'(out_count) == exp_c)
                else report_mismatch("count", exp_c, int'(out_count));
            assert (int'(out_pixel) == exp_pix)
                else report_mismatch("pixel order", exp_pix, int'(out_pixel));
            assert (int'(out_bin) == exp_bin)
                else report_mismatch("bin order", exp_bin, int'(out_bin));
            // bank 0 first, then alternating
            assert (int'(out_bank) == sets_read % 2)
                else report_mismatch("bank alternation", sets_read % 2, int'(out_bank));
            assert (int'(out_last) == int'(beat_idx == SET_BEATS - 1))
                else report_mismatch("last marker", int'(beat_idx == SET_BEATS - 1),
                                     int'(out_last));
            if (exp_c == COUNT_MAX && int'(out_count) == COUNT_MAX) begin
                sat_seen++;
            end
            if (lazy && int'(out_count) == 0) begin
                lazy_seen++;
            end
            outstanding++;
            assert (outstanding <= CREDITS)
                else report_failure("more beats outstanding at the sink than credits exist");
            if (beat_idx == SET_BEATS - 1) begin
                beat_idx   = 0;
                since_last = 0;
                sets_read++;
            end else begin
                beat_idx++;
            end
        end
    endtask

    // stall only at a set boundary, until two samples after the older set's last beat
    task automatic check_ready();
        int closed;
        closed = acc_total / SET_EVENTS;
        if (!ev_ready) begin
            assert (acc_in_set == 0 && closed > sets_read
                    && (sets_read < closed - 1 || since_last < 2))
                else report_failure("input stalled while no readout held the bank to reuse");
        end
    endtask

    task automatic drive_events();
        int set_idx;
        ev_valid = 1'b0;
        if (acc_total < TOTAL_EVENTS) begin
            set_idx = acc_total / SET_EVENTS;
            // valid three cycles out of four
            ev_valid = (rand_bits(2) != 0);
            if (rep_mode[set_idx]) begin
                ev_bin = rep_bin[set_idx];
            end else begin
                ev_bin = bin_idx_t'(rand_bits($bits(bin_idx_t)));
            end
        end
    endtask

    // credit sink with short and occasional long gaps
    task automatic drive_credit();
        credit_ret = 1'b0;
        if (gap_left > 0) begin
            gap_left--;
        end else if (outstanding > 0) begin
            credit_ret = 1'b1;
            outstanding--;
            if (rand_bits(3) == 0) begin
                gap_left = 16 + rand_bits(4);
            end else begin
                gap_left = rand_bits(3);
            end
        end
    endtask

    // sample mid-cycle, inputs and registered outputs settled
    always @(negedge clk) begin
        if (combin_res) begin
            if (ev_valid && ev_ready) begin
                apply_event(ev_bin);
            end else if (ev_valid) begin
                // offered during back-pressure, must be dropped
                stall_offers++;
            end
            since_last++;
            if (out_valid) begin
                check_beat();
            end
            check_ready();
        end
    end

    initial begin
        wait (combin_res === 1'b1);
        forever begin
            @(posedge clk);
            #0.5;
            drive_events();
            drive_credit();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, %0d of %0d sets read, %0d mismatches",
                 WATCHDOG_NS, sets_read, NUM_SETS, mism_errs);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int s;
        combin_res  = 1'b0;
        ev_valid    = 1'b0;
        ev_bin      = '0;
        credit_ret  = 1'b0;
        lfsr_q      = 16'd36294;
        fill_bank_m = 0;
        // half the sets hammer a single bin
        for (s = 0; s < NUM_SETS; s++) begin
            rep_mode[s] = (rand_bits(1) != 0);
            rep_bin[s]  = bin_idx_t'(rand_bits($bits(bin_idx_t)));
        end
        // at least one saturating set
        rep_mode[1] = 1'b1;
        repeat (16) @(posedge clk);
        #0.5;
        combin_res = 1'b1;
        @(negedge clk);
        assert (ev_ready === 1'b1 && out_valid === 1'b0 && out_last === 1'b0)
            else report_failure("outputs not at their idle values after reset");
        wait (sets_read == NUM_SETS);
        repeat (8) @(posedge clk);
        assert (exp_cnt_q.size() == 0)
            else report_failure("finished sets left in the model that were never read out");
        assert (beats_checked == NUM_SETS * SET_BEATS)
            else report_mismatch("beat total", NUM_SETS * SET_BEATS, beats_checked);
        assert (sat_seen > 0)
            else report_failure("no saturated bin was ever read back");
        assert (lazy_seen > 0)
            else report_failure("no bin cleared lazily from an older set was seen");
        assert (stall_offers > 0)
            else report_failure("input was never back-pressured during the run");
        $display("errors: %0d mismatch, %0d other; beats %0d sat %0d lazy %0d stall %0d",
                 mism_errs, other_errs, beats_checked, sat_seen, lazy_seen, stall_offers);
        if (mism_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
